// File: verilog/soc_mem_params.svh
// ----------------------------------------
// Fabric constants. CSR data is fixed at 32 bits
// ----------------------------------------
`ifndef SOC_MEM_PARAMS_SVH
`define SOC_MEM_PARAMS_SVH

// Memory word address width and word width
`define FML_DEPTH 10
`define FML_WIDTH 64

// Cycles from first strobe to acknowledge
`define RAM_LATENCY 3

// Reset release counts, in sys_clk cycles
`define RST_HOLD 64
`define FLASH_RST_CYCLES 32

// CSR unit numbers, matched against csr_a[13:10]
`define CSR_UNIT_SCANOUT 4'd3
`define CSR_UNIT_MEMTEST 4'd7
`define CSR_UNIT_METER 4'd9

// 16-bit pixels packed into one memory word
`define PIXELS_PER_WORD 4

`endif

// File: verilog/soc_mem_pkg.sv
// ----------------------------------------
// Types shared by the masters, the arbiter and the memory
// ----------------------------------------
`include "soc_mem_params.svh"

package soc_mem_pkg;

	// Word address on the memory side
	typedef logic [`FML_DEPTH-1:0] fml_adr_t;

	// Unit number in bits 13:10, register in bits 1:0
	typedef logic [13:0] csr_adr_t;

	// Scanout reads a word as pixels, pixel 0 lowest
	// Memtest builds and checks it as two 32-bit halves
	typedef union packed {
		logic [`PIXELS_PER_WORD-1:0][`FML_WIDTH/`PIXELS_PER_WORD-1:0] pixel;
		logic [1:0][`FML_WIDTH/2-1:0] half;
	} fml_word_t;

endpackage

// File: verilog/reset_gen.sv
`timescale 1ns/1ns
// ----------------------------------------
// Flash reset leaves reset before sys_rst
// Any trigger_reset pulse restarts both counts
// ----------------------------------------
`include "soc_mem_params.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);
	localparam int HOLD_W = $clog2(`RST_HOLD + 1);
	localparam int FLASH_W = $clog2(`FLASH_RST_CYCLES + 1);

	logic trigger_q;
	logic [HOLD_W-1:0] hold_cnt;
	logic [FLASH_W-1:0] flash_cnt;

	// Hold counter works from the sampled trigger
	always_ff @(posedge sys_clk) begin
		trigger_q <= trigger_reset;
		if (trigger_q) begin
			hold_cnt <= HOLD_W'(`RST_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
		sys_rst_o <= trigger_reset || (hold_cnt != '0);
	end

	// Flash counter saturates once released
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			flash_cnt <= '0;
			flash_rst_n_o <= 1'b0;
		end else begin
			if (flash_cnt != FLASH_W'(`FLASH_RST_CYCLES)) begin
				flash_cnt <= flash_cnt + 1'b1;
			end
			flash_rst_n_o <= (flash_cnt == FLASH_W'(`FLASH_RST_CYCLES));
		end
	end

endmodule

// File: verilog/fml_arbiter.sv
`timescale 1ns/1ns
// ----------------------------------------
// One transfer at a time, m0 wins ties
// An idle cycle separates consecutive grants
// ----------------------------------------

module fml_arbiter
	import soc_mem_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst_i,

	// Scanout, read only
	input  logic      m0_stb_i,
	input  fml_adr_t  m0_adr_i,
	output logic      m0_ack_o,
	output fml_word_t m0_dr_o,

	// Memtest
	input  logic      m1_stb_i,
	input  logic      m1_we_i,
	input  fml_adr_t  m1_adr_i,
	input  fml_word_t m1_dw_i,
	output logic      m1_ack_o,
	output fml_word_t m1_dr_o,

	// Memory side
	output logic      mem_stb_o,
	output logic      mem_we_o,
	output fml_adr_t  mem_adr_o,
	output fml_word_t mem_dw_o,
	input  logic      mem_ack_i,
	input  fml_word_t mem_dr_i
);
	logic busy;
	logic sel_m1;

	// ----------------------------------------
	// Grant register
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			busy <= 1'b0;
			sel_m1 <= 1'b0;
		end else if (!busy) begin
			if (m0_stb_i) begin
				busy <= 1'b1;
				sel_m1 <= 1'b0;
			end else if (m1_stb_i) begin
				busy <= 1'b1;
				sel_m1 <= 1'b1;
			end
		end else if (mem_ack_i) begin
			// Released in the cycle after the acknowledge
			busy <= 1'b0;
		end
	end

	// ----------------------------------------
	// Steering
	// ----------------------------------------
	assign mem_stb_o = busy && (sel_m1 ? m1_stb_i : m0_stb_i);
	assign mem_we_o  = sel_m1 && m1_we_i;
	assign mem_adr_o = sel_m1 ? m1_adr_i : m0_adr_i;
	assign mem_dw_o  = m1_dw_i;

	// Only the granted master sees the acknowledge
	assign m0_ack_o = busy && !sel_m1 && mem_ack_i;
	assign m1_ack_o = busy && sel_m1 && mem_ack_i;

	// Read data goes to both masters
	assign m0_dr_o = mem_dr_i;
	assign m1_dr_o = mem_dr_i;

endmodule

// File: verilog/fml_ram.sv
`timescale 1ns/1ns
// ----------------------------------------
// Whole-word memory model, no byte selects
// Strobe must drop in the cycle after ack
// ----------------------------------------
`include "soc_mem_params.svh"

module fml_ram
	import soc_mem_pkg::*;
(
	input  logic      sys_clk,
	input  logic      mem_stb_i,
	input  logic      mem_we_i,
	input  fml_adr_t  mem_adr_i,
	input  fml_word_t mem_dw_i,
	output logic      mem_ack_o,
	output fml_word_t mem_dr_o
);
	localparam int CNT_W = $clog2(`RAM_LATENCY + 1);

	fml_word_t mem [0:(1 << `FML_DEPTH)-1];
	logic [CNT_W-1:0] lat_cnt;
	logic hit;

	initial begin
		for (int i = 0; i < (1 << `FML_DEPTH); i++) begin
			mem[i] = '0;
		end
	end

	// Last wait cycle of the current strobe
	assign hit = mem_stb_i && !mem_ack_o && (lat_cnt == CNT_W'(`RAM_LATENCY - 1));

	// Counter self-clears while no strobe is present
	always_ff @(posedge sys_clk) begin
		if (!mem_stb_i || mem_ack_o) begin
			lat_cnt <= '0;
		end else begin
			lat_cnt <= lat_cnt + 1'b1;
		end
		mem_ack_o <= hit;
	end

	// Access happens on the edge that raises ack
	always_ff @(posedge sys_clk) begin
		if (hit) begin
			if (mem_we_i) begin
				mem[mem_adr_i] <= mem_dw_i;
			end
			mem_dr_o <= mem[mem_adr_i];
		end
	end

endmodule

// File: verilog/memtest.sv
`timescale 1ns/1ns
// ----------------------------------------
// Word at address a holds {a, ~a}, zero-extended halves
// Writing reg 0 during a run restarts it
// ----------------------------------------
`include "soc_mem_params.svh"

module memtest
	import soc_mem_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst_i,

	input  csr_adr_t    csr_a_i,
	input  logic        csr_we_i,
	input  logic [31:0] csr_dw_i,
	output logic [31:0] csr_dr_o,

	output logic        fml_stb_o,
	output logic        fml_we_o,
	output fml_adr_t    fml_adr_o,
	output fml_word_t   fml_dw_o,
	input  logic        fml_ack_i,
	input  fml_word_t   fml_dr_i
);
	logic csr_sel;
	logic busy;
	logic mode_q;
	fml_adr_t base_q;
	fml_adr_t adr_q;
	logic [`FML_DEPTH:0] remaining;
	logic [31:0] errors;
	logic [`FML_WIDTH/2-1:0] adr_ext;
	fml_word_t pattern;
	logic word_bad;

	assign csr_sel = (csr_a_i[13:10] == `CSR_UNIT_MEMTEST);

	// Expected word for the current address
	assign adr_ext = {{(`FML_WIDTH/2-`FML_DEPTH){1'b0}}, adr_q};
	always_comb begin
		pattern.half[1] = adr_ext;
		pattern.half[0] = ~adr_ext;
	end

	// One error per word, whichever half is wrong
	assign word_bad = (fml_dr_i.half[1] != pattern.half[1]) ||
		(fml_dr_i.half[0] != pattern.half[0]);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			busy <= 1'b0;
			mode_q <= 1'b0;
			base_q <= '0;
			adr_q <= '0;
			remaining <= '0;
			errors <= '0;
			csr_dr_o <= '0;
		end else begin
			// ----------------------------------------
			// Walk
			// ----------------------------------------
			if (busy && fml_ack_i) begin
				if (!mode_q && word_bad) begin
					errors <= errors + 1'b1;
				end
				adr_q <= adr_q + 1'b1;
				remaining <= remaining - 1'b1;
				if (remaining == 1) begin
					busy <= 1'b0;
				end
			end

			// ----------------------------------------
			// CSR access, a start write wins over the walk
			// ----------------------------------------
			if (csr_sel && csr_we_i) begin
				case (csr_a_i[1:0])
					2'd0: begin
						busy <= (csr_dw_i[`FML_DEPTH:0] != '0);
						remaining <= csr_dw_i[`FML_DEPTH:0];
						adr_q <= base_q;
						errors <= '0;
					end
					2'd1: base_q <= csr_dw_i[`FML_DEPTH-1:0];
					2'd2: mode_q <= csr_dw_i[0];
					default: ;
				endcase
			end

			csr_dr_o <= '0;
			if (csr_sel) begin
				case (csr_a_i[1:0])
					2'd0: csr_dr_o <= {31'd0, busy};
					2'd1: csr_dr_o <= 32'(base_q);
					2'd2: csr_dr_o <= {31'd0, mode_q};
					default: csr_dr_o <= errors;
				endcase
			end
		end
	end

	// Request stays up for the whole run
	assign fml_stb_o = busy;
	assign fml_we_o  = mode_q;
	assign fml_adr_o = adr_q;
	assign fml_dw_o  = pattern;

endmodule

// File: verilog/scanout.sv
`timescale 1ns/1ns
// ----------------------------------------
// No back-pressure on pixels. Disable takes effect at frame end
// ----------------------------------------
`include "soc_mem_params.svh"

module scanout
	import soc_mem_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst_i,

	input  csr_adr_t    csr_a_i,
	input  logic        csr_we_i,
	input  logic [31:0] csr_dw_i,
	output logic [31:0] csr_dr_o,

	output logic        fml_stb_o,
	output fml_adr_t    fml_adr_o,
	input  logic        fml_ack_i,
	input  fml_word_t   fml_dr_i,

	output logic [15:0] pixel_o,
	output logic        pixel_valid_o,
	output logic        frame_end_o
);
	localparam int PH_W = $clog2(`PIXELS_PER_WORD);
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(`PIXELS_PER_WORD - 1);

	logic csr_sel;
	logic enable_q;
	fml_adr_t base_q;
	logic [`FML_DEPTH:0] length_q;
	logic [31:0] frames_q;
	fml_adr_t idx_q;
	logic stb_q;
	logic last_q;
	logic last_word;
	logic [PH_W-1:0] phase;
	fml_word_t word_q;

	assign csr_sel = (csr_a_i[13:10] == `CSR_UNIT_SCANOUT);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			enable_q <= 1'b0;
			base_q <= '0;
			length_q <= '0;
			csr_dr_o <= '0;
		end else begin
			if (csr_sel && csr_we_i) begin
				case (csr_a_i[1:0])
					2'd0: enable_q <= csr_dw_i[0];
					2'd1: base_q <= csr_dw_i[`FML_DEPTH-1:0];
					2'd2: length_q <= csr_dw_i[`FML_DEPTH:0];
					default: ;
				endcase
			end
			csr_dr_o <= '0;
			if (csr_sel) begin
				case (csr_a_i[1:0])
					2'd0: csr_dr_o <= {31'd0, enable_q};
					2'd1: csr_dr_o <= 32'(base_q);
					2'd2: csr_dr_o <= 32'(length_q);
					default: csr_dr_o <= frames_q;
				endcase
			end
		end
	end

	// ----------------------------------------
	// Fetch and shift
	// ----------------------------------------
	assign last_word = ({1'b0, idx_q} == length_q - 1'b1);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			stb_q <= 1'b0;
			phase <= '0;
			idx_q <= '0;
			last_q <= 1'b0;
			frames_q <= '0;
		end else if (fml_ack_i) begin
			// Pixel 0 goes out in the ack cycle itself
			stb_q <= 1'b0;
			phase <= PH_W'(1);
			last_q <= last_word;
			idx_q <= last_word ? '0 : idx_q + 1'b1;
		end else if (phase != '0) begin
			phase <= (phase == PH_LAST) ? '0 : phase + 1'b1;
			if (phase == PH_LAST) begin
				if (!last_q || (enable_q && length_q != '0)) begin
					stb_q <= 1'b1;
				end
				if (last_q) begin
					frames_q <= frames_q + 1'b1;
				end
			end
		end else if (!stb_q && enable_q && length_q != '0) begin
			// Idle between frames
			stb_q <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (fml_ack_i) begin
			word_q <= fml_dr_i;
		end
	end

	assign fml_stb_o = stb_q;
	assign fml_adr_o = base_q + idx_q;

	assign pixel_valid_o = fml_ack_i || (phase != '0);
	assign pixel_o = fml_ack_i ? fml_dr_i.pixel[0] : word_q.pixel[phase];
	assign frame_end_o = (phase == PH_LAST) && last_q;

endmodule

// File: verilog/fml_meter.sv
`timescale 1ns/1ns
// ----------------------------------------
// Counters wrap at 32 bits
// ----------------------------------------
`include "soc_mem_params.svh"

module fml_meter
	import soc_mem_pkg::*;
(
	input  logic        sys_clk,
	input  logic        sys_rst_i,

	input  csr_adr_t    csr_a_i,
	input  logic        csr_we_i,
	input  logic [31:0] csr_dw_i,
	output logic [31:0] csr_dr_o,

	input  logic        mem_stb_i,
	input  logic        mem_ack_i
);
	logic csr_sel;
	logic enable_q;
	logic [31:0] stb_cnt;
	logic [31:0] ack_cnt;

	assign csr_sel = (csr_a_i[13:10] == `CSR_UNIT_METER);

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			enable_q <= 1'b0;
			stb_cnt <= '0;
			ack_cnt <= '0;
			csr_dr_o <= '0;
		end else begin
			if (enable_q && mem_stb_i) begin
				stb_cnt <= stb_cnt + 1'b1;
			end
			if (enable_q && mem_ack_i) begin
				ack_cnt <= ack_cnt + 1'b1;
			end
			// Writing 1 restarts from zero, 0 freezes
			if (csr_sel && csr_we_i && csr_a_i[1:0] == 2'd0) begin
				enable_q <= csr_dw_i[0];
				if (csr_dw_i[0]) begin
					stb_cnt <= '0;
					ack_cnt <= '0;
				end
			end
			csr_dr_o <= '0;
			if (csr_sel) begin
				case (csr_a_i[1:0])
					2'd0: csr_dr_o <= {31'd0, enable_q};
					2'd1: csr_dr_o <= stb_cnt;
					2'd2: csr_dr_o <= ack_cnt;
					default: csr_dr_o <= '0;
				endcase
			end
		end
	end

endmodule

// File: verilog/soc_mem.sv
`timescale 1ns/1ns
// ----------------------------------------
// Unaddressed units return zero, so CSR reads are ORed
// ----------------------------------------

module soc_mem
	import soc_mem_pkg::*;
(
	input  logic        sys_clk,
	input  logic        trigger_reset,

	input  csr_adr_t    csr_a_i,
	input  logic        csr_we_i,
	input  logic [31:0] csr_dw_i,
	output logic [31:0] csr_dr_o,

	output logic [15:0] pixel_o,
	output logic        pixel_valid_o,
	output logic        frame_end_o,

	output logic        flash_rst_n_o,
	output logic        periph_rst_n_o
);
	logic sys_rst;
	logic [31:0] csr_dr_scanout;
	logic [31:0] csr_dr_memtest;
	logic [31:0] csr_dr_meter;

	// Scanout master, high priority
	logic m0_stb;
	fml_adr_t m0_adr;
	logic m0_ack;
	fml_word_t m0_dr;

	// Memtest master, low priority
	logic m1_stb;
	logic m1_we;
	fml_adr_t m1_adr;
	fml_word_t m1_dw;
	logic m1_ack;
	fml_word_t m1_dr;

	// Memory port
	logic mem_stb;
	logic mem_we;
	fml_adr_t mem_adr;
	fml_word_t mem_dw;
	logic mem_ack;
	fml_word_t mem_dr;

	// ----------------------------------------
	// Reset
	// ----------------------------------------
	reset_gen reset_gen_i (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	// ----------------------------------------
	// Masters
	// ----------------------------------------
	scanout scanout_i (
		.sys_clk       (sys_clk),
		.sys_rst_i     (sys_rst),
		.csr_a_i       (csr_a_i),
		.csr_we_i      (csr_we_i),
		.csr_dw_i      (csr_dw_i),
		.csr_dr_o      (csr_dr_scanout),
		.fml_stb_o     (m0_stb),
		.fml_adr_o     (m0_adr),
		.fml_ack_i     (m0_ack),
		.fml_dr_i      (m0_dr),
		.pixel_o       (pixel_o),
		.pixel_valid_o (pixel_valid_o),
		.frame_end_o   (frame_end_o)
	);

	memtest memtest_i (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.csr_a_i   (csr_a_i),
		.csr_we_i  (csr_we_i),
		.csr_dw_i  (csr_dw_i),
		.csr_dr_o  (csr_dr_memtest),
		.fml_stb_o (m1_stb),
		.fml_we_o  (m1_we),
		.fml_adr_o (m1_adr),
		.fml_dw_o  (m1_dw),
		.fml_ack_i (m1_ack),
		.fml_dr_i  (m1_dr)
	);

	// ----------------------------------------
	// Arbiter, memory and meter
	// ----------------------------------------
	fml_arbiter fml_arbiter_i (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.m0_stb_i  (m0_stb),
		.m0_adr_i  (m0_adr),
		.m0_ack_o  (m0_ack),
		.m0_dr_o   (m0_dr),
		.m1_stb_i  (m1_stb),
		.m1_we_i   (m1_we),
		.m1_adr_i  (m1_adr),
		.m1_dw_i   (m1_dw),
		.m1_ack_o  (m1_ack),
		.m1_dr_o   (m1_dr),
		.mem_stb_o (mem_stb),
		.mem_we_o  (mem_we),
		.mem_adr_o (mem_adr),
		.mem_dw_o  (mem_dw),
		.mem_ack_i (mem_ack),
		.mem_dr_i  (mem_dr)
	);

	fml_ram fml_ram_i (
		.sys_clk   (sys_clk),
		.mem_stb_i (mem_stb),
		.mem_we_i  (mem_we),
		.mem_adr_i (mem_adr),
		.mem_dw_i  (mem_dw),
		.mem_ack_o (mem_ack),
		.mem_dr_o  (mem_dr)
	);

	fml_meter fml_meter_i (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.csr_a_i   (csr_a_i),
		.csr_we_i  (csr_we_i),
		.csr_dw_i  (csr_dw_i),
		.csr_dr_o  (csr_dr_meter),
		.mem_stb_i (mem_stb),
		.mem_ack_i (mem_ack)
	);

	assign csr_dr_o = csr_dr_scanout | csr_dr_memtest | csr_dr_meter;

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ns
// ----------------------------------------
// Free-running clock, starts low
// ----------------------------------------

module tb_clock #(
	parameter int HALF_PERIOD = 5
) (
	output logic clk_o
);
	initial begin
		clk_o = 1'b0;
		forever begin
			#(HALF_PERIOD) clk_o = ~clk_o;
		end
	end

endmodule

// File: dv/soc_mem_tb.sv
`timescale 1ns/1ns
// ----------------------------------------
// Runs from the project root, reads dv/soc_mem_patterns.txt
// Inputs change on the falling edge, outputs are sampled there too
// ----------------------------------------
`include "soc_mem_params.svh"

module soc_mem_tb;
	localparam int MAX_OPS = 64;
	localparam int OP_FIELDS = 4;
	localparam int CYCLES_PER_OP = 2000;
	localparam int PIXEL_WAIT = 200;
	localparam int DRAIN_IDLE = 64;

	localparam logic [31:0] OP_WRITE = 32'h1;
	localparam logic [31:0] OP_READ = 32'h2;
	localparam logic [31:0] OP_POLL = 32'h3;
	localparam logic [31:0] OP_SCANOUT = 32'h4;
	localparam logic [31:0] OP_END = 32'hFFFF_FFFF;

	localparam logic [13:0] SCANOUT_CTRL = {`CSR_UNIT_SCANOUT, 10'd0};
	localparam logic [13:0] SCANOUT_BASE = {`CSR_UNIT_SCANOUT, 10'd1};
	localparam logic [13:0] SCANOUT_LEN = {`CSR_UNIT_SCANOUT, 10'd2};
	localparam logic [13:0] MEMTEST_STATUS = {`CSR_UNIT_MEMTEST, 10'd0};

	logic sys_clk;
	logic trigger_reset;
	logic [13:0] csr_a;
	logic csr_we;
	logic [31:0] csr_dw;
	logic [31:0] csr_dr;
	logic [15:0] pixel;
	logic pixel_valid;
	logic frame_end;
	logic flash_rst_n;
	logic periph_rst_n;

	// Four fields per operation: opcode, then three arguments
	logic [31:0] ops [0:MAX_OPS*OP_FIELDS-1];
	int n_ops;
	int watchdog_cycles;
	bit ops_loaded;
	int pixel_idx;

	tb_clock clock_i (
		.clk_o (sys_clk)
	);

	soc_mem soc_mem_i (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.csr_a_i        (csr_a),
		.csr_we_i       (csr_we),
		.csr_dw_i       (csr_dw),
		.csr_dr_o       (csr_dr),
		.pixel_o        (pixel),
		.pixel_valid_o  (pixel_valid),
		.frame_end_o    (frame_end),
		.flash_rst_n_o  (flash_rst_n),
		.periph_rst_n_o (periph_rst_n)
	);

	// ----------------------------------------
	// Failure reporting and checks
	// ----------------------------------------
	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else
			stop_on_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic check_at_least(input string name, input logic [31:0] got,
			input logic [31:0] min);
		assert (got >= min) else
			stop_on_failure($sformatf("Mismatch %s: got 0x%0h, expected at least 0x%0h",
				name, got, min));
	endtask

	// Word at address a is {zext(a), ~zext(a)}, pixel 0 in bits 15:0
	function automatic logic [15:0] expected_pixel(input int base, input int len, input int idx);
		logic [`FML_DEPTH-1:0] adr;
		logic [31:0] high;
		logic [63:0] word;
		logic [63:0] shifted;
		adr = `FML_DEPTH'(base + (idx / `PIXELS_PER_WORD) % len);
		high = 32'(adr);
		word = {high, ~high};
		shifted = word >> (16 * (idx % `PIXELS_PER_WORD));
		return shifted[15:0];
	endfunction

	// ----------------------------------------
	// Bus access
	// ----------------------------------------
	task automatic csr_write(input logic [13:0] adr, input logic [31:0] data);
		csr_a = adr;
		csr_dw = data;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	// Data is registered one cycle after the address
	task automatic csr_read(input logic [13:0] adr, output logic [31:0] data);
		csr_a = adr;
		csr_we = 1'b0;
		@(negedge sys_clk);
		data = csr_dr;
	endtask

	task automatic wait_memtest_idle(input int limit);
		logic [31:0] busy;
		int polls;
		polls = 0;
		busy = 32'd1;
		while (busy != 0) begin
			assert (polls < limit) else
				stop_on_failure($sformatf("memtest still busy after %0d polls", limit));
			csr_read(MEMTEST_STATUS, busy);
			polls++;
		end
	endtask

	// ----------------------------------------
	// Scanout
	// ----------------------------------------
	task automatic check_pixel(input int base, input int len);
		int frame_pixels;
		frame_pixels = len * `PIXELS_PER_WORD;
		check_value($sformatf("pixel_o[%0d]", pixel_idx), 32'(pixel),
			32'(expected_pixel(base, len, pixel_idx)));
		check_value($sformatf("frame_end_o[%0d]", pixel_idx), 32'(frame_end),
			32'(pixel_idx % frame_pixels == frame_pixels - 1));
		pixel_idx++;
	endtask

	task automatic run_scanout(input int base, input int len, input int count);
		int idle;
		bit drained;
		pixel_idx = 0;
		csr_write(SCANOUT_BASE, 32'(base));
		csr_write(SCANOUT_LEN, 32'(len));
		csr_write(SCANOUT_CTRL, 32'd1);
		idle = 0;
		while (pixel_idx < count) begin
			@(negedge sys_clk);
			if (pixel_valid) begin
				check_pixel(base, len);
				idle = 0;
			end else begin
				idle++;
				assert (idle < PIXEL_WAIT) else
					stop_on_failure($sformatf("no pixel from scanout within %0d cycles",
						PIXEL_WAIT));
			end
		end

		// Frame in flight still completes after disable
		csr_write(SCANOUT_CTRL, 32'd0);
		idle = 0;
		drained = 1'b0;
		while (!drained) begin
			if (pixel_valid) begin
				drained = frame_end;
				check_pixel(base, len);
				idle = 0;
			end else begin
				idle++;
				drained = (idle >= DRAIN_IDLE);
			end
			if (!drained) begin
				@(negedge sys_clk);
			end
		end
		assert (pixel_idx % (len * `PIXELS_PER_WORD) == 0) else
			stop_on_failure($sformatf("scanout stopped inside a frame after %0d pixels",
				pixel_idx));
		repeat (2) @(negedge sys_clk);
	endtask

	// ----------------------------------------
	// Reset release and operation dispatch
	// ----------------------------------------
	task automatic check_reset_release();
		for (int k = 0; k <= `RST_HOLD + 4; k++) begin
			@(negedge sys_clk);
			check_value("flash_rst_n_o", 32'(flash_rst_n), 32'(k >= `FLASH_RST_CYCLES));
			check_value("periph_rst_n_o", 32'(periph_rst_n), 32'(k >= `RST_HOLD + 1));
			check_value("pixel_valid_o", 32'(pixel_valid), 32'd0);
		end
	endtask

	task automatic run_op(input int n);
		logic [31:0] op;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] data;
		op = ops[n*OP_FIELDS];
		f1 = ops[n*OP_FIELDS+1];
		f2 = ops[n*OP_FIELDS+2];
		f3 = ops[n*OP_FIELDS+3];
		case (op)
			OP_WRITE: csr_write(f1[13:0], f2);
			OP_READ: begin
				csr_read(f1[13:0], data);
				if (f3 == 0) begin
					check_value($sformatf("csr_dr_o at 0x%0h", f1[13:0]), data, f2);
				end else begin
					check_at_least($sformatf("csr_dr_o at 0x%0h", f1[13:0]), data, f2);
				end
			end
			OP_POLL: wait_memtest_idle(int'(f1));
			OP_SCANOUT: run_scanout(int'(f1), int'(f2), int'(f3));
			default: stop_on_failure($sformatf("unknown opcode 0x%0h in operation %0d", op, n));
		endcase
	endtask

	initial begin
		trigger_reset = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_dw = '0;
		for (int i = 0; i < MAX_OPS * OP_FIELDS; i++) begin
			ops[i] = OP_END;
		end
		$readmemh("dv/soc_mem_patterns.txt", ops);
		n_ops = 0;
		while (n_ops < MAX_OPS && ops[n_ops*OP_FIELDS] != OP_END) begin
			n_ops++;
		end
		watchdog_cycles = (n_ops + 1) * CYCLES_PER_OP;
		ops_loaded = 1'b1;
		assert (n_ops > 0) else
			stop_on_failure("pattern file held no operations");

		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		trigger_reset = 1'b0;
		check_reset_release();

		for (int i = 0; i < n_ops; i++) begin
			run_op(i);
		end
		$display("Everything OK");
		$finish;
	end

	// Limit scales with the number of operations
	initial begin
		wait (ops_loaded);
		repeat (watchdog_cycles) @(posedge sys_clk);
		stop_on_failure($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
	end

endmodule

// File: soc_mem.f
+incdir+verilog
verilog/soc_mem_pkg.sv
verilog/reset_gen.sv
verilog/fml_arbiter.sv
verilog/fml_ram.sv
verilog/memtest.sv
verilog/scanout.sv
verilog/fml_meter.sv
verilog/soc_mem.sv
dv/tb_clock.sv
dv/soc_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run soc_mem_tb with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f soc_mem.f --top-module soc_mem_tb -o soc_mem_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/soc_mem_sim > sim.log 2>&1 || echo "simulator returned an error status"
[ -f sim.log ] && cat sim.log || { echo "no simulation log"; exit 1; }
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"

// File: dv/soc_mem_patterns.txt
// Columns: opcode, then three hex fields. 1 write: adr data 0. 2 read: adr expected mode
// 2 mode 0 is equal, 1 is at least. 3 poll memtest: limit 0 0. 4 scanout: base length pixels
1 1c01 40 0
1 1c02 1 0
1 1c00 10 0
3 100 0 0
1 1c02 0 0
1 1c00 10 0
3 100 0 0
2 1c03 0 0
2 1c01 40 0
// Verify 0x4c to 0x53, upper four words never written
1 1c01 4c 0
1 1c00 8 0
3 100 0 0
2 1c03 4 0
4 40 2 8
2 0c03 1 1
// Meter around a 16-word verify
1 2400 1 0
1 1c01 40 0
1 1c00 10 0
3 100 0 0
2 1c03 0 0
2 2402 10 0
2 2401 10 1
// Memtest writes 0x60 while scanout runs
1 1c01 60 0
1 1c02 1 0
1 1c00 10 0
2 1c00 1 0
4 40 2 10
3 100 0 0
1 1c02 0 0
1 1c00 10 0
3 100 0 0
2 1c03 0 0
